// File: test/dutlb_read_trace.txt
# E idx vld ppn flg pgs   (entry table, hex; missing slots are random and invalid)
# R va va_vld abort lsu_id read_type off_hit expt refill_on ref_pgflt refill_id
#   dmw_hit dmw_mat priv entry_hit  pa pa_vld pf so ca miss miss_short id_match
#   id_older  pmp_chk_vld plru_hit   (registered pair is seen one cycle later)
E 0 1 7654321 01d3 1
E 1 1 abcde00 01d3 2
E 2 1 8f00000 01d3 4
E 3 1 0000111 01d2 1
E 4 1 0000222 00d3 1
E 5 1 0000333 01c3 1
# translation by page size, 4k then level 1 then level 2
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0101 7654321 1 0 0 1 0 0 0 0 1 0001
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0002 abcdf67 1 0 0 1 0 0 0 0 1 0002
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0004 8f34567 1 0 0 1 0 0 0 0 1 0004
# direct mapping with dmw attributes
R 0000001234567abc 1 0 05 1 1 0 0 0 03 1 0 3 0000 1234567 1 0 1 0 0 0 0 0 1 0000
R 0000001234567abc 1 0 05 1 1 0 0 0 03 1 1 0 0000 1234567 1 0 0 1 0 0 0 0 1 0000
# faults, invalid entry, store to read-only, store to writable
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0008 0000111 1 1 0 1 0 0 0 0 0 0008
R 0000001234567abc 1 0 05 0 0 0 0 0 03 0 0 0 0010 0000222 1 1 0 1 0 0 0 0 0 0010
R 0000001234567abc 1 0 05 0 0 0 0 0 03 0 0 0 0001 7654321 1 0 0 1 0 0 0 0 1 0001
# refill page fault for the same id
R 0000001234567abc 1 0 05 1 0 0 1 1 05 0 0 0 0001 7654321 1 1 0 1 0 0 1 0 0 0001
# strongly ordered page
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0020 0000333 1 0 1 0 0 0 0 0 1 0020
# miss, hit on an invalid slot only
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0400 0000000 0 0 1 0 1 1 0 0 0 0000
# miss with abort
R 0000001234567abc 1 1 05 1 0 0 0 0 05 0 0 0 0000 0000000 0 0 1 0 0 1 0 0 0 0000
# id age, same wrap then differing wrap
R 0000001234567abc 1 0 05 1 0 0 0 0 10 0 0 0 0000 0000000 0 0 1 0 1 1 0 1 0 0000
R 0000001234567abc 1 0 45 1 0 0 0 0 10 0 0 0 0000 0000000 0 0 1 0 1 1 0 0 0 0000
R 0000001234567abc 1 0 50 1 0 0 0 0 05 0 0 0 0000 0000000 0 0 1 0 1 1 0 1 0 0000
R 0000001234567abc 1 0 07 1 0 0 0 0 45 0 0 0 0000 0000000 0 0 1 0 1 1 0 1 0 0000
# exception delivery for the matching id
R 0000001234567abc 1 0 05 1 0 1 0 0 05 0 0 0 0000 0000000 1 0 1 0 1 1 1 0 0 0000
# plru holds across an idle cycle
R 0000001234567abc 1 0 05 1 0 0 0 0 03 0 0 0 0002 abcdf67 1 0 0 1 0 0 0 0 1 0002
R 0000001234567abc 0 0 05 1 0 0 0 0 03 0 0 0 0000 1234567 0 0 1 0 0 0 0 0 0 0002
# abort on a hit masks only the id outputs
R 0000001234567abc 1 1 05 1 0 0 0 0 10 0 0 0 0001 7654321 1 0 0 1 0 0 0 0 1 0001

// File: build.f
hw/dutlb_pkg.sv
hw/dutlb_entry_match.sv
hw/dutlb_pa_compose.sv
hw/dutlb_resp_check.sv
hw/dutlb_pmp_pabuf.sv
hw/dutlb_read.sv
test/dutlb_read_assertions.sv
test/tb_dutlb_read.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_dutlb_read -o Vtb_dutlb_read
	./obj_dir/Vtb_dutlb_read > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_dutlb_read.sv
// trace-driven testbench for the data micro-tlb read side
`timescale 1ns/1ps

module tb_dutlb_read
  import dutlb_pkg::*;
();

  // ----------------------------------------------------------------------
  // dut signals
  // ----------------------------------------------------------------------
  logic       pabuf_clk;
  logic       cpurst_b;
  va_t        va;
  logic       va_vld;
  logic       abort;
  iid_t       lsu_id;
  logic       read_type;
  logic       off_hit;
  logic       expt_for_taken;
  logic       refill_on;
  logic       ref_pgflt;
  iid_t       refill_id;
  logic       dmw_hit;
  mat_t       dmw_mat;
  plv_t       priv_mode;
  entry_vec_t entry_vld;
  entry_vec_t entry_hit;
  ppn_t       entry_ppn [entry_num];
  flg_t       entry_flg [entry_num];
  pgs_t       entry_pgs [entry_num];
  ppn_t       mmu_lsu_pa;
  logic       mmu_lsu_pa_vld;
  logic       mmu_lsu_page_fault;
  logic       mmu_lsu_so;
  logic       mmu_lsu_ca;
  logic       dutlb_miss_vld;
  logic       dutlb_miss_vld_short;
  logic       dutlb_inst_id_match;
  logic       dutlb_inst_id_older;
  entry_vec_t dutlb_plru_read_hit;
  logic       dutlb_plru_read_hit_vld;
  logic       mmu_pmp_chk_vld;
  logic       mmu_pmp_read_type;
  ppn_t       mmu_pmp_pa;

  // trace row, request part then expected part
  va_t        r_va;
  logic       r_vld, r_abort, r_rd, r_off, r_expt, r_ron, r_rpf, r_dmwh;
  iid_t       r_lsu, r_rid;
  mat_t       r_dmwm;
  plv_t       r_priv;
  entry_vec_t r_hit;
  ppn_t       x_pa;
  logic       x_pavld, x_pf, x_so, x_ca, x_miss, x_short, x_idm, x_ido, x_chk;
  entry_vec_t x_plru;

  // registered expectations, one request behind
  logic       q_chk;
  logic       q_rdt;
  ppn_t       q_pa;
  entry_vec_t q_plru;
  logic       q_have;

  int         val_errs;
  int         oth_errs;
  string      lines [$];
  logic       filled [entry_num];

  dutlb_read dut0 (.*);

  bind dutlb_read dutlb_read_assertions u_assertions (
    .pabuf_clk          (pabuf_clk),
    .cpurst_b           (cpurst_b),
    .off_hit            (off_hit),
    .expt_for_taken     (expt_for_taken),
    .mmu_lsu_pa_vld     (mmu_lsu_pa_vld),
    .mmu_lsu_page_fault (mmu_lsu_page_fault),
    .dutlb_miss_vld     (dutlb_miss_vld),
    .mmu_pmp_chk_vld    (mmu_pmp_chk_vld)
  );

  // ----------------------------------------------------------------------
  // clock, reset, watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    pabuf_clk = 1'b0;
    forever #20 pabuf_clk = ~pabuf_clk;
  end

  initial
  begin
    cpurst_b = 1'b0;
    repeat (3) @(posedge pabuf_clk);
    cpurst_b <= 1'b1;
  end

  initial
  begin
    #200000;
    $display("run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_vec(input string name, input entry_vec_t got, input entry_vec_t exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  // entry lines set the table, blank slots get random invalid contents
  task automatic load_trace();
    int          fd;
    int          n;
    int          guard;
    int          idx;
    string       line;
    logic        e_vld;
    ppn_t        e_ppn;
    flg_t        e_flg;
    pgs_t        e_pgs;
    logic [31:0] rnd;
    fd = $fopen("test/dutlb_read_trace.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the trace file");
      oth_errs++;
      return;
    end
    guard = 0;
    while (!$feof(fd) && guard < 1000)
    begin
      n = $fgets(line, fd);
      if (n > 0)
        lines.push_back(line);
      guard++;
    end
    $fclose(fd);
    foreach (lines[i])
    begin
      if (lines[i].substr(0, 0) == "E")
      begin
        n = $sscanf(lines[i], "E %d %h %h %h %h", idx, e_vld, e_ppn, e_flg, e_pgs);
        if (n != 5 || idx < 0 || idx >= entry_num)
        begin
          $display("malformed entry line %0d in the trace", i);
          oth_errs++;
        end
        else
        begin
          entry_vld[idx[3:0]] = e_vld;
          entry_ppn[idx[3:0]] = e_ppn;
          entry_flg[idx[3:0]] = e_flg;
          entry_pgs[idx[3:0]] = e_pgs;
          filled[idx[3:0]]    = 1'b1;
        end
      end
    end
    rnd = 32'h3024;
    for (int i = 0; i < entry_num; i++)
    begin
      if (!filled[i])
      begin
        rnd = next_rand(rnd);
        entry_ppn[i] = rnd[27:0];
        rnd = next_rand(rnd);
        entry_flg[i] = rnd[13:0];
        entry_pgs[i] = rnd[2:0];
        entry_vld[i] = 1'b0;
      end
    end
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (cpurst_b !== 1'b1 && cnt < 20)
    begin
      @(posedge pabuf_clk);
      cnt++;
    end
    if (cpurst_b !== 1'b1)
    begin
      $display("reset was not released in time");
      oth_errs++;
    end
  endtask

  task automatic apply_request();
    va             <= r_va;
    va_vld         <= r_vld;
    abort          <= r_abort;
    lsu_id         <= r_lsu;
    read_type      <= r_rd;
    off_hit        <= r_off;
    expt_for_taken <= r_expt;
    refill_on      <= r_ron;
    ref_pgflt      <= r_rpf;
    refill_id      <= r_rid;
    dmw_hit        <= r_dmwh;
    dmw_mat        <= r_dmwm;
    priv_mode      <= r_priv;
    entry_hit      <= r_hit;
  endtask

  task automatic check_comb();
    check_ppn("mmu_lsu_pa", mmu_lsu_pa, x_pa);
    check_bit("mmu_lsu_pa_vld", mmu_lsu_pa_vld, x_pavld);
    check_bit("mmu_lsu_page_fault", mmu_lsu_page_fault, x_pf);
    check_bit("mmu_lsu_so", mmu_lsu_so, x_so);
    check_bit("mmu_lsu_ca", mmu_lsu_ca, x_ca);
    check_bit("dutlb_miss_vld", dutlb_miss_vld, x_miss);
    check_bit("dutlb_miss_vld_short", dutlb_miss_vld_short, x_short);
    check_bit("dutlb_inst_id_match", dutlb_inst_id_match, x_idm);
    check_bit("dutlb_inst_id_older", dutlb_inst_id_older, x_ido);
  endtask

  task automatic check_regs();
    check_bit("mmu_pmp_chk_vld", mmu_pmp_chk_vld, q_chk);
    check_vec("dutlb_plru_read_hit", dutlb_plru_read_hit, q_plru);
    check_bit("dutlb_plru_read_hit_vld", dutlb_plru_read_hit_vld, |q_plru);
    check_bit("mmu_pmp_read_type", mmu_pmp_read_type, q_rdt);
    if (q_chk)
      check_ppn("mmu_pmp_pa", mmu_pmp_pa, q_pa);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    int n;
    va = '0;
    va_vld = 1'b0;
    abort = 1'b0;
    lsu_id = '0;
    read_type = 1'b0;
    off_hit = 1'b0;
    expt_for_taken = 1'b0;
    refill_on = 1'b0;
    ref_pgflt = 1'b0;
    refill_id = '0;
    dmw_hit = 1'b0;
    dmw_mat = '0;
    priv_mode = '0;
    entry_hit = '0;
    entry_vld = '0;
    val_errs = 0;
    oth_errs = 0;
    q_chk = 1'b0;
    q_rdt = 1'b0;
    q_pa = '0;
    q_plru = '0;
    q_have = 1'b0;
    for (int i = 0; i < entry_num; i++)
    begin
      filled[i] = 1'b0;
      entry_ppn[i] = '0;
      entry_flg[i] = '0;
      entry_pgs[i] = '0;
    end
    load_trace();
    wait_reset_release();
    // registered outputs come out of reset clear
    #10;
    check_regs();
    foreach (lines[i])
    begin
      if (lines[i].substr(0, 0) == "R")
      begin
        n = $sscanf(lines[i],
          "R %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          r_va, r_vld, r_abort, r_lsu, r_rd, r_off, r_expt, r_ron, r_rpf, r_rid,
          r_dmwh, r_dmwm, r_priv, r_hit, x_pa, x_pavld, x_pf, x_so, x_ca,
          x_miss, x_short, x_idm, x_ido, x_chk, x_plru);
        if (n != 25)
        begin
          $display("malformed request line %0d in the trace", i);
          oth_errs++;
        end
        else
        begin
          @(posedge pabuf_clk);
          apply_request();
          #30;
          if (q_have)
            check_regs();
          check_comb();
          q_have = 1'b1;
          q_chk  = x_chk;
          q_plru = x_plru;
          if (x_chk)
          begin
            q_pa  = x_pa;
            q_rdt = r_rd;
          end
        end
      end
    end
    // drain the last request out of the register stage
    @(posedge pabuf_clk);
    va_vld    <= 1'b0;
    entry_hit <= '0;
    #30;
    check_regs();
    $display("checks done, %0d value errors, %0d other errors", val_errs, oth_errs);
    if (val_errs == 0 && oth_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: test/dutlb_read_assertions.sv
// bound port checks on the micro-tlb read side, miss, fault and reset rules
`timescale 1ns/1ps

module dutlb_read_assertions (
  input logic pabuf_clk,
  input logic cpurst_b,
  input logic off_hit,
  input logic expt_for_taken,
  input logic mmu_lsu_pa_vld,
  input logic mmu_lsu_page_fault,
  input logic dutlb_miss_vld,
  input logic mmu_pmp_chk_vld
);

  // ----------------------------------------------------------------------
  // response rules
  // ----------------------------------------------------------------------
  // a miss never comes with a valid pa unless direct map or exception
  miss_no_pa: assert property (
    @(posedge pabuf_clk) disable iff (!cpurst_b)
    (dutlb_miss_vld && !off_hit && !expt_for_taken) |-> !mmu_lsu_pa_vld
  ) else $error("miss with valid pa");

  // translation off never faults
  off_no_fault: assert property (
    @(posedge pabuf_clk) disable iff (!cpurst_b)
    off_hit |-> !mmu_lsu_page_fault
  ) else $error("page fault with translation off");

  // ----------------------------------------------------------------------
  // reset
  // ----------------------------------------------------------------------
  rst_chk_low: assert property (
    @(posedge pabuf_clk)
    !cpurst_b |-> !mmu_pmp_chk_vld
  ) else $error("pmp check valid during reset");

endmodule

// File: hw/dutlb_read.sv
// data micro-tlb read side top, entry match, address composition and response
`timescale 1ns/1ps

module dutlb_read
  import dutlb_pkg::*;
(
  input  logic       pabuf_clk,
  input  logic       cpurst_b,
  // lsu request
  input  va_t        va,
  input  logic       va_vld,
  input  logic       abort,
  input  iid_t       lsu_id,
  input  logic       read_type,
  // mode and refill state
  input  logic       off_hit,
  input  logic       expt_for_taken,
  input  logic       refill_on,
  input  logic       ref_pgflt,
  input  iid_t       refill_id,
  input  logic       dmw_hit,
  input  mat_t       dmw_mat,
  input  plv_t       priv_mode,
  // entry contents
  input  entry_vec_t entry_vld,
  input  entry_vec_t entry_hit,
  input  ppn_t       entry_ppn [entry_num],
  input  flg_t       entry_flg [entry_num],
  input  pgs_t       entry_pgs [entry_num],
  // same-cycle response
  output ppn_t       mmu_lsu_pa,
  output logic       mmu_lsu_pa_vld,
  output logic       mmu_lsu_page_fault,
  output logic       mmu_lsu_so,
  output logic       mmu_lsu_ca,
  output logic       dutlb_miss_vld,
  output logic       dutlb_miss_vld_short,
  output logic       dutlb_inst_id_match,
  output logic       dutlb_inst_id_older,
  // registered
  output entry_vec_t dutlb_plru_read_hit,
  output logic       dutlb_plru_read_hit_vld,
  output logic       mmu_pmp_chk_vld,
  output logic       mmu_pmp_read_type,
  output ppn_t       mmu_pmp_pa
);

  entry_vec_t hit_vec;
  ppn_t       sel_ppn;
  flg_t       sel_flg;
  pgs_t       sel_pgs;
  ppn_t       fin_ppn;
  flg_t       fin_flg;
  logic       expt_match;
  logic       pmp_chk_vld;

  // ----------------------------------------------------------------------
  // decode, entry match
  // ----------------------------------------------------------------------
  dutlb_entry_match u_entry_match (
    .entry_vld (entry_vld),
    .entry_hit (entry_hit),
    .entry_ppn (entry_ppn),
    .entry_flg (entry_flg),
    .entry_pgs (entry_pgs),
    .hit_vec   (hit_vec),
    .sel_ppn   (sel_ppn),
    .sel_flg   (sel_flg),
    .sel_pgs   (sel_pgs)
  );

  // execute, pa composition
  dutlb_pa_compose u_pa_compose (
    .va         (va),
    .va_vld     (va_vld),
    .off_hit    (off_hit),
    .expt_match (expt_match),
    .dmw_mat    (dmw_mat),
    .priv_mode  (priv_mode),
    .sel_ppn    (sel_ppn),
    .sel_flg    (sel_flg),
    .sel_pgs    (sel_pgs),
    .fin_ppn    (fin_ppn),
    .fin_flg    (fin_flg)
  );

  assign mmu_lsu_pa = fin_ppn;

  // ----------------------------------------------------------------------
  // result, checks and pmp buffer
  // ----------------------------------------------------------------------
  dutlb_resp_check u_resp_check (
    .va_vld         (va_vld),
    .abort          (abort),
    .off_hit        (off_hit),
    .read_type      (read_type),
    .refill_on      (refill_on),
    .ref_pgflt      (ref_pgflt),
    .expt_for_taken (expt_for_taken),
    .lsu_id         (lsu_id),
    .refill_id      (refill_id),
    .dmw_hit        (dmw_hit),
    .dmw_mat        (dmw_mat),
    .hit_vec        (hit_vec),
    .fin_flg        (fin_flg),
    .pa_vld         (mmu_lsu_pa_vld),
    .page_fault     (mmu_lsu_page_fault),
    .miss_vld       (dutlb_miss_vld),
    .miss_vld_short (dutlb_miss_vld_short),
    .id_match       (dutlb_inst_id_match),
    .id_older       (dutlb_inst_id_older),
    .expt_match     (expt_match),
    .attr_so        (mmu_lsu_so),
    .attr_ca        (mmu_lsu_ca),
    .pmp_chk_vld    (pmp_chk_vld)
  );

  dutlb_pmp_pabuf u_pmp_pabuf (
    .pabuf_clk         (pabuf_clk),
    .cpurst_b          (cpurst_b),
    .va_vld            (va_vld),
    .hit_vec           (hit_vec),
    .pmp_chk_vld       (pmp_chk_vld),
    .read_type         (read_type),
    .fin_ppn           (fin_ppn),
    .plru_read_hit     (dutlb_plru_read_hit),
    .plru_read_hit_vld (dutlb_plru_read_hit_vld),
    .pmp_chk_vld_q     (mmu_pmp_chk_vld),
    .pmp_read_type     (mmu_pmp_read_type),
    .mmu_pmp_pa        (mmu_pmp_pa)
  );

endmodule

// File: hw/dutlb_pmp_pabuf.sv
// result register stage, plru hit vector and physical address buffer for pmp
`timescale 1ns/1ps

module dutlb_pmp_pabuf
  import dutlb_pkg::*;
(
  input  logic       pabuf_clk,
  input  logic       cpurst_b,
  input  logic       va_vld,
  input  entry_vec_t hit_vec,
  input  logic       pmp_chk_vld,
  input  logic       read_type,
  input  ppn_t       fin_ppn,
  output entry_vec_t plru_read_hit,
  output logic       plru_read_hit_vld,
  output logic       pmp_chk_vld_q,
  output logic       pmp_read_type,
  output ppn_t       mmu_pmp_pa
);

  // ----------------------------------------------------------------------
  // plru update
  // ----------------------------------------------------------------------
  // holds the last request's hit vector
  always_ff @(posedge pabuf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      plru_read_hit <= '0;
    else if (va_vld)
      plru_read_hit <= hit_vec;
  end

  assign plru_read_hit_vld = |plru_read_hit;

  // ----------------------------------------------------------------------
  // pmp check buffer
  // ----------------------------------------------------------------------
  always_ff @(posedge pabuf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pmp_chk_vld_q <= 1'b0;
      pmp_read_type <= 1'b0;
    end
    else
    begin
      pmp_chk_vld_q <= pmp_chk_vld;
      if (pmp_chk_vld)
        pmp_read_type <= read_type;
    end
  end

  // pa payload, qualified by pmp_chk_vld_q
  always_ff @(posedge pabuf_clk)
  begin
    if (pmp_chk_vld)
      mmu_pmp_pa <= fin_ppn;
  end

endmodule

// File: hw/dutlb_resp_check.sv
// response check, judges hit, fault, miss, id compare and memory attributes
`timescale 1ns/1ps

module dutlb_resp_check
  import dutlb_pkg::*;
(
  input  logic       va_vld,
  input  logic       abort,
  input  logic       off_hit,
  input  logic       read_type,
  input  logic       refill_on,
  input  logic       ref_pgflt,
  input  logic       expt_for_taken,
  input  iid_t       lsu_id,
  input  iid_t       refill_id,
  input  logic       dmw_hit,
  input  mat_t       dmw_mat,
  input  entry_vec_t hit_vec,
  input  flg_t       fin_flg,
  output logic       pa_vld,
  output logic       page_fault,
  output logic       miss_vld,
  output logic       miss_vld_short,
  output logic       id_match,
  output logic       id_older,
  output logic       expt_match,
  output logic       attr_so,
  output logic       attr_ca,
  output logic       pmp_chk_vld
);

  logic addr_hit;
  logic id_hit;
  logic fault_int;
  logic wrap_eq;
  logic low_lt;
  logic low_gt;
  logic lsu_older;
  mat_t fin_mat;

  // ----------------------------------------------------------------------
  // hit and id match
  // ----------------------------------------------------------------------
  assign addr_hit = |hit_vec;
  // request is the one the refill is working for
  assign id_hit = va_vld && (refill_id == lsu_id);
  assign expt_match = expt_for_taken && id_hit;

  // translation done this cycle
  assign pa_vld = va_vld && (addr_hit || off_hit || expt_match);

  // ----------------------------------------------------------------------
  // page fault
  // ----------------------------------------------------------------------
  // invalid entry, or store to a read-only page
  // refill walk faulted for this id
  assign fault_int = (addr_hit
                       && (!fin_flg[flg_v] || (!fin_flg[flg_w] && !read_type)))
                  || (ref_pgflt && refill_on && id_hit);

  // no faults with translation off
  assign page_fault = fault_int && !off_hit;

  // ----------------------------------------------------------------------
  // miss and id outputs
  // ----------------------------------------------------------------------
  assign miss_vld_short = va_vld && !addr_hit && !off_hit;
  assign miss_vld = miss_vld_short && !abort;

  assign id_match = id_hit && !abort;

  // age compare, wrap bit flips the sense of the low bits
  assign wrap_eq = lsu_id[iid_width-1] == refill_id[iid_width-1];
  assign low_lt = lsu_id[iid_width-2:0] < refill_id[iid_width-2:0];
  assign low_gt = lsu_id[iid_width-2:0] > refill_id[iid_width-2:0];
  assign lsu_older = wrap_eq ? low_lt : low_gt;

  assign id_older = va_vld && !abort && lsu_older;

  // ----------------------------------------------------------------------
  // memory attributes
  // ----------------------------------------------------------------------
  assign fin_mat = fin_flg[flg_mat_lo +: 2];
  // mat 0 is strongly ordered device space
  assign attr_so = dmw_hit ? (dmw_mat == 2'b00) : (fin_mat == 2'b00);
  assign attr_ca = (fin_mat != 2'b00) && !attr_so;

  // pa goes to pmp only for a clean hit or direct map
  assign pmp_chk_vld = va_vld && (addr_hit || off_hit) && !fault_int;

endmodule

// File: hw/dutlb_pa_compose.sv
// address composition that merges the va offset by page size and applies direct mapping
`timescale 1ns/1ps

module dutlb_pa_compose
  import dutlb_pkg::*;
(
  input  va_t  va,
  input  logic va_vld,
  input  logic off_hit,
  input  logic expt_match,
  input  mat_t dmw_mat,
  input  plv_t priv_mode,
  input  ppn_t sel_ppn,
  input  flg_t sel_flg,
  input  pgs_t sel_pgs,
  output ppn_t fin_ppn,
  output flg_t fin_flg
);

  ppn_t mix_ppn;
  ppn_t off_ppn;
  flg_t off_flg;
  logic off_sel;
  logic pre_sel;

  // ----------------------------------------------------------------------
  // translated address
  // ----------------------------------------------------------------------
  // huge pages take low ppn bits from the va
  assign mix_ppn =
      ({ppn_width{sel_pgs[pgs_lvl2]}}
        & {sel_ppn[ppn_width-1:2*lvl_bits], va[2*lvl_bits+11:12]})
    | ({ppn_width{sel_pgs[pgs_lvl1]}}
        & {sel_ppn[ppn_width-1:lvl_bits], va[lvl_bits+11:12]})
    | ({ppn_width{sel_pgs[pgs_4k]}} & sel_ppn);

  // ----------------------------------------------------------------------
  // direct-mapped address and flags
  // ----------------------------------------------------------------------
  // translation off or no request this cycle
  assign off_sel = off_hit || !va_vld;
  // exception delivery also bypasses the entry
  assign pre_sel = off_sel || expt_match;

  // va[38] is the kernel window bit and is dropped
  assign off_ppn = off_sel ? {2'b00, va[vpn_width+10:12]} : '0;

  always_comb
  begin
    off_flg = '0;
    if (off_sel)
    begin
      // W, P and H
      off_flg[flg_w]                = 1'b1;
      off_flg[flg_w-1]              = 1'b1;
      off_flg[flg_w-2]              = 1'b1;
      off_flg[flg_mat_lo +: 2]      = dmw_mat;
      off_flg[flg_plv_lo +: 2]      = priv_mode;
    end
  end

  // final select
  assign fin_ppn = pre_sel ? off_ppn : mix_ppn;
  assign fin_flg = pre_sel ? off_flg : sel_flg;

endmodule

// File: hw/dutlb_entry_match.sv
// entry match stage, builds the hit vector and selects the hit entry's fields
`timescale 1ns/1ps

module dutlb_entry_match
  import dutlb_pkg::*;
(
  input  entry_vec_t entry_vld,
  input  entry_vec_t entry_hit,
  input  ppn_t       entry_ppn [entry_num],
  input  flg_t       entry_flg [entry_num],
  input  pgs_t       entry_pgs [entry_num],
  output entry_vec_t hit_vec,
  output ppn_t       sel_ppn,
  output flg_t       sel_flg,
  output pgs_t       sel_pgs
);

  // set when two or more entries hit at once
  logic multi_hit;

  // ----------------------------------------------------------------------
  // hit vector
  // ----------------------------------------------------------------------
  // only valid entries may report a vpn match
  assign hit_vec = entry_vld & entry_hit;

  // clearing the lowest set bit leaves something only on multi-hit
  assign multi_hit = |(hit_vec & (hit_vec - entry_vec_t'(1)));

  // ----------------------------------------------------------------------
  // one-hot field select
  // ----------------------------------------------------------------------
  always_comb
  begin
    sel_ppn = '0;
    sel_flg = '0;
    sel_pgs = '0;
    // and-or mux over all entries
    for (int i = 0; i < entry_num; i++)
    begin
      sel_ppn = sel_ppn | ({ppn_width{hit_vec[i]}} & entry_ppn[i]);
      sel_flg = sel_flg | ({flg_width{hit_vec[i]}} & entry_flg[i]);
      sel_pgs = sel_pgs | ({pgs_width{hit_vec[i]}} & entry_pgs[i]);
    end
    // multi-hit gives no usable entry
    if (multi_hit)
    begin
      sel_ppn = '0;
      sel_flg = '0;
      sel_pgs = '0;
    end
  end

endmodule

// File: hw/dutlb_pkg.sv
// data micro-tlb read side shared widths, flag layout and page-size encoding
package dutlb_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int entry_num = 16;
  // 40-bit pa minus page offset
  localparam int ppn_width = 28;
  // 39-bit va minus page offset
  localparam int vpn_width = 27;
  localparam int flg_width = 14;
  localparam int pgs_width = 3;
  // offset bits per page level
  localparam int lvl_bits  = 9;
  localparam int iid_width = 7;
  localparam int va_width  = 64;

  // ----------------------------------------------------------------------
  // page-table flag bit positions
  // ----------------------------------------------------------------------
  // valid
  localparam int flg_v      = 0;
  // dirty
  localparam int flg_d      = 1;
  // plv field, 2 bits
  localparam int flg_plv_lo = 2;
  // mat field, 2 bits
  localparam int flg_mat_lo = 4;
  // write permission, P and H sit just below it
  localparam int flg_w      = 8;

  // one-hot page size positions
  localparam int pgs_4k   = 0;
  localparam int pgs_lvl1 = 1;
  localparam int pgs_lvl2 = 2;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [ppn_width-1:0] ppn_t;
  typedef logic [flg_width-1:0] flg_t;
  typedef logic [pgs_width-1:0] pgs_t;
  typedef logic [entry_num-1:0] entry_vec_t;
  // msb is the wrap bit
  typedef logic [iid_width-1:0] iid_t;
  typedef logic [va_width-1:0]  va_t;
  typedef logic [1:0]           mat_t;
  typedef logic [1:0]           plv_t;

endpackage
